// File: bus_defs.svh
/* bus subsystem parameters */

`ifndef BUS_DEFS_SVH
`define BUS_DEFS_SVH

// bus widths
`define BUS_AW 32               // byte address
`define BUS_DW 32               // data word

// memory slave
`define BUS_MEM_WORDS 256       // byte addresses 0x000..0x3ff
`define BUS_MEM_LATENCY 2       // pulse to ack, at least 2

// upper region, writes need machine mode
`define BUS_PRIV_BASE 32'h0000_0300

// keeper watchdog, must exceed the memory latency
`define BUS_TIMEOUT 8

`endif

// File: bus_keeper.sv
/* bus access watchdog */

`default_nettype none

`include "bus_defs.svh"

module bus_keeper (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  bus_pkg::bus_req_t req_i,
    input  bus_pkg::bus_rsp_t rsp_i,
    output logic              err_o
);
    import bus_pkg::*;

    localparam int CNT_W = $clog2(`BUS_TIMEOUT + 1);

    logic             active_q;     // access outstanding
    logic [CNT_W-1:0] cnt_q;        // cycles since the pulse
    logic             err_q;
    logic             pulse;
    logic             answered;

    assign pulse    = req_i.re | req_i.we;
    assign answered = rsp_i.ack | rsp_i.err;

    // ----------------------------------------------------------
    // timeout counter
    // ----------------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            active_q <= 1'b0;
            cnt_q    <= '0;
            err_q    <= 1'b0;
        end else begin
            err_q <= 1'b0;  // single-cycle pulse
            if (pulse) begin
                active_q <= 1'b1;
                cnt_q    <= CNT_W'(1);
            end else if (active_q) begin
                if (answered) begin
                    active_q <= 1'b0;   // some slave took it
                end else if (cnt_q == CNT_W'(`BUS_TIMEOUT - 1)) begin
                    err_q    <= 1'b1;   // shows up TIMEOUT cycles after the pulse
                    active_q <= 1'b0;
                end else begin
                    cnt_q <= cnt_q + 1'b1;
                end
            end
        end
    end

    assign err_o = err_q;

endmodule

`default_nettype wire

// File: bus_mem.sv
/* word memory slave */

`default_nettype none

`include "bus_defs.svh"

module bus_mem (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  bus_pkg::bus_req_t req_i,
    output bus_pkg::bus_rsp_t rsp_o
);
    import bus_pkg::*;

    localparam int IDX_W = $clog2(`BUS_MEM_WORDS);
    localparam int CNT_W = $clog2(`BUS_MEM_LATENCY + 1);
    localparam int NBYTE = `BUS_DW / 8;

    logic [`BUS_DW-1:0] mem_q [`BUS_MEM_WORDS];

    bus_req_t           acc_q;      // latched access
    logic               pend_q;     // access in flight
    logic [CNT_W-1:0]   cnt_q;      // cycles left before the answer edge
    logic [`BUS_DW-1:0] rdata_q;
    logic               ack_q, err_q;

    logic [IDX_W-1:0]   idx;
    logic               pulse;
    logic               fire;       // answer registered at this edge
    logic               in_range;
    logic               priv_viol;

    assign pulse = req_i.re | req_i.we;
    assign idx   = acc_q.addr[IDX_W+1:2];   // word index
    assign fire  = pend_q & (cnt_q == CNT_W'(1));

    assign in_range  = acc_q.addr[`BUS_AW-1:2] < `BUS_MEM_WORDS;
    assign priv_viol = acc_q.we & ~acc_q.priv & (acc_q.addr >= `BUS_PRIV_BASE);

    // ----------------------------------------------------------
    // latency counter and answer flags
    // ----------------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pend_q <= 1'b0;
            cnt_q  <= '0;
            ack_q  <= 1'b0;
            err_q  <= 1'b0;
        end else begin
            // out of range leaves both low, keeper answers
            ack_q <= fire & in_range & ~priv_viol;
            err_q <= fire & in_range & priv_viol;
            if (pulse) begin
                pend_q <= 1'b1;
                cnt_q  <= CNT_W'(`BUS_MEM_LATENCY - 1);
            end else if (fire) begin
                pend_q <= 1'b0;
            end else if (pend_q) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    // ----------------------------------------------------------
    // storage
    // ----------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (pulse) begin
            acc_q <= req_i;     // master holds it anyway
        end
        if (fire) begin
            rdata_q <= mem_q[idx];  // old word on writes
            if (acc_q.we && in_range && !priv_viol) begin
                for (int b = 0; b < NBYTE; b++) begin
                    if (acc_q.ben[b]) begin
                        mem_q[idx][8*b +: 8] <= acc_q.wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    always_comb begin
        rsp_o.rdata = rdata_q;
        rsp_o.ack   = ack_q;
        rsp_o.err   = err_q;
    end

endmodule

`default_nettype wire

// File: bus_pkg.sv
/* bus request and response types */

`default_nettype none

`include "bus_defs.svh"

package bus_pkg;

    // one controller access, same layout on ca, cb and the peripheral bus
    typedef struct packed {
        logic                   priv;   // 1 = machine mode
        logic                   cached; // carried only
        logic [`BUS_AW-1:0]     addr;   // byte address
        logic [`BUS_DW-1:0]     wdata;
        logic [`BUS_DW/8-1:0]   ben;    // byte enables
        logic                   we;     // single-cycle write pulse
        logic                   re;     // single-cycle read pulse
    } bus_req_t;

    // slave answer, ack or err for exactly one cycle
    typedef struct packed {
        logic [`BUS_DW-1:0]     rdata;  // valid with ack on reads
        logic                   ack;
        logic                   err;
    } bus_rsp_t;

endpackage

`default_nettype wire

// File: bus_switch.sv
/* two-port prioritized bus switch */

`default_nettype none

module bus_switch #(
    parameter bit PORT_CA_READ_ONLY = 1'b0,
    parameter bit PORT_CB_READ_ONLY = 1'b0
) (
    input  logic              clk_i,
    input  logic              rstn_i,
    // controller port a, data side
    input  bus_pkg::bus_req_t ca_req_i,
    output bus_pkg::bus_rsp_t ca_rsp_o,
    // controller port b, fetch side
    input  bus_pkg::bus_req_t cb_req_i,
    output bus_pkg::bus_rsp_t cb_rsp_o,
    // peripheral bus
    output bus_pkg::bus_req_t p_req_o,
    output logic              p_src_o,  // 0 = a owns the bus, 1 = b
    input  bus_pkg::bus_rsp_t p_rsp_i
);
    import bus_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_A_BUSY,
        S_A_RETIRE,
        S_B_BUSY,
        S_B_RETIRE
    } arb_state_e;

    arb_state_e state_q, state_d;
    logic       bus_sel;            // current owner
    logic       re_trig, we_trig;   // re-issue of a buffered pulse

    // per-port request buffers
    logic ca_rd_buf_q, ca_wr_buf_q;
    logic cb_rd_buf_q, cb_wr_buf_q;

    logic ca_we, cb_we;             // write pulses after read-only masking
    logic ca_req_cur, ca_req_pend;
    logic cb_req_cur, cb_req_pend;
    logic ca_ack, ca_err;
    logic cb_ack, cb_err;
    bus_req_t sel_req;

    // ----------------------------------------------------------
    // request bookkeeping
    // ----------------------------------------------------------
    assign ca_we = ca_req_i.we & ~PORT_CA_READ_ONLY;  // dropped on read-only port
    assign cb_we = cb_req_i.we & ~PORT_CB_READ_ONLY;

    assign ca_req_cur  = ca_req_i.re | ca_we;
    assign cb_req_cur  = cb_req_i.re | cb_we;
    assign ca_req_pend = ca_rd_buf_q | ca_wr_buf_q;
    assign cb_req_pend = cb_rd_buf_q | cb_wr_buf_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q     <= S_IDLE;
            ca_rd_buf_q <= 1'b0;
            ca_wr_buf_q <= 1'b0;
            cb_rd_buf_q <= 1'b0;
            cb_wr_buf_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // set on the pulse, held until the port sees its answer
            ca_rd_buf_q <= (ca_rd_buf_q | ca_req_i.re) & ~(ca_ack | ca_err);
            ca_wr_buf_q <= (ca_wr_buf_q | ca_we) & ~(ca_ack | ca_err);
            cb_rd_buf_q <= (cb_rd_buf_q | cb_req_i.re) & ~(cb_ack | cb_err);
            cb_wr_buf_q <= (cb_wr_buf_q | cb_we) & ~(cb_ack | cb_err);
        end
    end

    // ----------------------------------------------------------
    // arbiter FSM, a before b, current before pending
    // ----------------------------------------------------------
    always_comb begin
        state_d = state_q;
        bus_sel = 1'b0;
        re_trig = 1'b0;
        we_trig = 1'b0;
        case (state_q)
            S_IDLE: begin
                if (ca_req_cur) begin
                    state_d = S_A_BUSY;     // passes through this cycle
                end else if (ca_req_pend) begin
                    state_d = S_A_RETIRE;
                end else if (cb_req_cur) begin
                    bus_sel = 1'b1;
                    state_d = S_B_BUSY;
                end else if (cb_req_pend) begin
                    bus_sel = 1'b1;
                    state_d = S_B_RETIRE;
                end
            end
            S_A_BUSY: begin
                if (p_rsp_i.ack || p_rsp_i.err) begin
                    state_d = S_IDLE;
                end
            end
            S_A_RETIRE: begin
                re_trig = ca_rd_buf_q;      // replay the stored pulse
                we_trig = ca_wr_buf_q;
                state_d = S_A_BUSY;
            end
            S_B_BUSY: begin
                bus_sel = 1'b1;
                if (p_rsp_i.ack || p_rsp_i.err) begin
                    // a waited, serve it next
                    if (ca_req_cur || ca_req_pend) begin
                        state_d = S_A_RETIRE;
                    end else begin
                        state_d = S_IDLE;
                    end
                end
            end
            S_B_RETIRE: begin
                bus_sel = 1'b1;
                re_trig = cb_rd_buf_q;
                we_trig = cb_wr_buf_q;
                state_d = S_B_BUSY;
            end
            default: begin
                state_d = S_IDLE;
            end
        endcase
    end

    // ----------------------------------------------------------
    // peripheral bus mux and response routing
    // ----------------------------------------------------------
    assign sel_req = bus_sel ? cb_req_i : ca_req_i;

    always_comb begin
        p_req_o    = sel_req;   // addr, data, ben, priv, cached
        p_req_o.we = (bus_sel ? cb_we : ca_we) | we_trig;
        p_req_o.re = sel_req.re | re_trig;
    end

    assign p_src_o = bus_sel;

    assign ca_ack = ~bus_sel & p_rsp_i.ack;
    assign ca_err = ~bus_sel & p_rsp_i.err;
    assign cb_ack = bus_sel & p_rsp_i.ack;
    assign cb_err = bus_sel & p_rsp_i.err;

    always_comb begin
        ca_rsp_o.rdata = p_rsp_i.rdata;     // shared read data
        ca_rsp_o.ack   = ca_ack;
        ca_rsp_o.err   = ca_err;
        cb_rsp_o.rdata = p_rsp_i.rdata;
        cb_rsp_o.ack   = cb_ack;
        cb_rsp_o.err   = cb_err;
    end

endmodule

`default_nettype wire

// File: bus_sys_top.sv
/* two-master memory subsystem */

`default_nettype none

module bus_sys_top (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  bus_pkg::bus_req_t ca_req_i,     // data port
    output bus_pkg::bus_rsp_t ca_rsp_o,
    input  bus_pkg::bus_req_t cb_req_i,     // fetch port
    output bus_pkg::bus_rsp_t cb_rsp_o,
    output logic              p_src_o       // current bus owner
);
    import bus_pkg::*;

    bus_req_t p_req;
    bus_rsp_t p_rsp;
    bus_rsp_t mem_rsp;
    logic     keeper_err;

    // a read-write, b read-only
    bus_switch #(
        .PORT_CA_READ_ONLY (1'b0),
        .PORT_CB_READ_ONLY (1'b1)
    ) u_switch (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .ca_req_i (ca_req_i),
        .ca_rsp_o (ca_rsp_o),
        .cb_req_i (cb_req_i),
        .cb_rsp_o (cb_rsp_o),
        .p_req_o  (p_req),
        .p_src_o  (p_src_o),
        .p_rsp_i  (p_rsp)
    );

    bus_mem u_mem (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .req_i  (p_req),
        .rsp_o  (mem_rsp)
    );

    bus_keeper u_keeper (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .req_i  (p_req),
        .rsp_i  (p_rsp),
        .err_o  (keeper_err)
    );

    // merge slave answers, only the memory has data
    always_comb begin
        p_rsp.rdata = mem_rsp.rdata;
        p_rsp.ack   = mem_rsp.ack;
        p_rsp.err   = mem_rsp.err | keeper_err;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+.
bus_pkg.sv
bus_switch.sv
bus_mem.sv
bus_keeper.sv
bus_sys_top.sv
tb_bus_sys.sv

// File: tb_bus_sys.sv
/* bus subsystem testbench */

`default_nettype none

`include "bus_defs.svh"

module tb_bus_sys;
    timeunit 1ns;
    timeprecision 100ps;

    import bus_pkg::*;

    logic     clk_i;
    logic     rstn_i;
    bus_req_t ca_req, cb_req;
    bus_rsp_t ca_rsp, cb_rsp;
    logic     p_src;

    logic [`BUS_DW-1:0] model [`BUS_MEM_WORDS];  // mirror of acked writes
    logic [31:0] seed = 32'd88;
    int          errors = 0;
    int          base = 0;                       // error count at test start
    int          tests_run = 0;
    int          tests_failed = 0;
    bit          a_ack, a_err, a_src, b_ack, b_err, b_src;
    time         t_a, t_b;
    logic [31:0] r, rb, wd, addr, baddr;

    bus_sys_top uut (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .ca_req_i (ca_req),
        .ca_rsp_o (ca_rsp),
        .cb_req_i (cb_req),
        .cb_rsp_o (cb_rsp),
        .p_src_o  (p_src)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;     // 20 ns period
    end

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------
    function logic [31:0] lcg();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function logic [31:0] fill_word(input logic [31:0] a);
        return (a * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;     // every address bit counts
    endfunction

    function void mismatch(input string msg);
        $display("Fail at %0d ns: %s", $time, msg);
        errors++;
    endfunction

    // one access on port a or b; silent waits out a window expecting no answer
    task automatic access(input bit port_b, input bit wr, input bit priv,
                          input logic [31:0] a, input logic [31:0] wdata,
                          input logic [3:0] ben, input bit silent,
                          output bit ack, output bit err, output bit src);
        bus_req_t req;
        bus_rsp_t rsp;
        int       n;
        int       limit;
        req   = {priv, 1'b0, a, wdata, ben, wr, ~wr};
        limit = silent ? 20 : 40;
        ack   = 1'b0;
        err   = 1'b0;
        src   = 1'b0;
        n     = 0;
        @(negedge clk_i);
        if (port_b)
            cb_req = req;
        else
            ca_req = req;
        while (n < limit && (silent || !(ack || err))) begin
            @(negedge clk_i);
            if (port_b) begin   // pulse lasts one cycle, rest is held
                cb_req.re = 1'b0;
                cb_req.we = 1'b0;
            end else begin
                ca_req.re = 1'b0;
                ca_req.we = 1'b0;
            end
            rsp = port_b ? cb_rsp : ca_rsp;
            if (rsp.ack || rsp.err)
                src = p_src;    // owner at answer time
            ack |= rsp.ack;
            err |= rsp.err;
            n++;
        end
        if (!silent && !(ack || err)) begin
            $display("Timeout: port %s got no answer for address %h in %0d cycles",
                     port_b ? "B" : "A", a, limit);
            errors++;
        end
        if (ack && wr) begin
            for (int b = 0; b < 4; b++) begin
                if (ben[b])
                    model[a[9:2]][8*b +: 8] = wdata[8*b +: 8];
            end
        end
        if (ack && !wr && !silent) begin
            assert (rsp.rdata === model[a[9:2]])
                else mismatch($sformatf("read %h gave %h, expected %h",
                                        a, rsp.rdata, model[a[9:2]]));
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors != base)
            tests_failed++;
        $display("test %0d %s: %s", tests_run, name, (errors == base) ? "ok" : "FAILED");
        base = errors;
    endtask

    // ------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------
    initial begin
        rstn_i = 1'b0;
        ca_req = '0;
        cb_req = '0;
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rstn_i = 1'b1;

        // fill whole memory, then partial byte writes
        for (int i = 0; i < `BUS_MEM_WORDS; i++) begin
            access(0, 1, 1, 4*i, fill_word(4*i), 4'hf, 0, a_ack, a_err, a_src);
            assert (a_ack) else mismatch($sformatf("fill write %0d not acked", i));
        end
        for (int i = 0; i < 8; i++) begin
            access(0, 1, 0, 4*i, lcg(), 4'(i + 1), 0, a_ack, a_err, a_src);
            assert (a_ack && !a_err) else mismatch("partial write on A not acked");
            access(0, 0, 0, 4*i, 0, 4'hf, 0, a_ack, a_err, a_src);
            assert (a_ack && !a_err) else mismatch("read on A not acked");
        end
        finish_test("basic access on A");

        for (int i = 0; i < 8; i++) begin
            access(1, 0, 0, 4*i, 0, 4'hf, 0, b_ack, b_err, b_src);
            assert (b_ack && !b_err) else mismatch("read on B not acked");
        end
        access(1, 1, 1, 32'h0c, 32'hdead_beef, 4'hf, 1, b_ack, b_err, b_src);
        assert (!b_ack && !b_err) else mismatch("write on read-only B was answered");
        access(0, 0, 0, 32'h0c, 0, 4'hf, 0, a_ack, a_err, a_src);     // word unchanged
        assert (a_ack) else mismatch("read after B write not acked");
        finish_test("read-only port B");

        fork
            begin
                access(0, 0, 0, 32'h10, 0, 4'hf, 0, a_ack, a_err, a_src);
                t_a = $time;
            end
            begin
                access(1, 0, 0, 32'h20, 0, 4'hf, 0, b_ack, b_err, b_src);
                t_b = $time;
            end
        join
        assert (a_ack && b_ack && t_a < t_b) else mismatch("A did not win same-cycle race");
        assert (a_src == 1'b0 && b_src == 1'b1) else mismatch("wrong p_src_o at the acks");
        fork
            access(0, 1, 0, 32'h40, lcg(), 4'hf, 0, a_ack, a_err, a_src);
            begin
                @(negedge clk_i);   // lands while A owns the bus
                access(1, 0, 0, 32'h40, 0, 4'hf, 0, b_ack, b_err, b_src);
            end
        join
        assert (a_ack && b_ack) else mismatch("request made during busy switch lost");
        finish_test("arbitration order");

        access(0, 1, 0, 32'h310, 32'h1234_5678, 4'hf, 0, a_ack, a_err, a_src);
        assert (a_err && !a_ack) else mismatch("user write to 0x310 not refused");
        access(0, 0, 0, 32'h310, 0, 4'hf, 0, a_ack, a_err, a_src);
        assert (a_ack) else mismatch("read of 0x310 not acked");
        access(0, 1, 1, 32'h310, 32'h1234_5678, 4'hf, 0, a_ack, a_err, a_src);
        assert (a_ack && !a_err) else mismatch("machine write to 0x310 refused");
        access(0, 0, 0, 32'h310, 0, 4'hf, 0, a_ack, a_err, a_src);
        assert (a_ack) else mismatch("read of 0x310 not acked");
        finish_test("privilege protection");

        access(0, 0, 0, 32'h800, 0, 4'hf, 0, a_ack, a_err, a_src);
        assert (a_err && !a_ack) else mismatch("unmapped read not flagged by keeper");
        access(0, 0, 0, 32'h08, 0, 4'hf, 0, a_ack, a_err, a_src);
        assert (a_ack && !a_err) else mismatch("access after keeper error failed");
        finish_test("unmapped address");

        for (int i = 0; i < 40; i++) begin
            r     = lcg();
            wd    = lcg();
            rb    = lcg();
            addr  = (r % 192) * 4;      // below the privileged region
            baddr = (rb % 192) * 4;
            fork
                access(0, r[20], 0, addr, wd, r[3:0], 0, a_ack, a_err, a_src);
                begin
                    repeat (rb[17:16]) @(negedge clk_i);   // vary the overlap
                    access(1, 0, 0, baddr, 0, 4'hf, 0, b_ack, b_err, b_src);
                end
            join
            assert (a_ack && b_ack && !a_err && !b_err)
                else mismatch($sformatf("random access %0d not acked on both ports", i));
        end
        finish_test("random traffic");

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire
